//--- source/mips_pkg.sv
package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Data and instruction word
    typedef logic [31:0] word_t;
    // Byte address, PC and data RAM
    typedef logic [7:0]  addr_t;
    // Register number
    typedef logic [4:0]  reg_idx_t;

    // Memory depths in words
    localparam int ROM_WORDS = 64;
    localparam int RAM_WORDS = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode field, bits 31 to 26
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OPC_RTYPE = 6'b000000;
    localparam logic [5:0] OPC_LW    = 6'b100011;
    localparam logic [5:0] OPC_SW    = 6'b101011;
    localparam logic [5:0] OPC_ADDI  = 6'b001000;
    localparam logic [5:0] OPC_ORI   = 6'b001101;
    localparam logic [5:0] OPC_SLTI  = 6'b001010;
    localparam logic [5:0] OPC_BEQ   = 6'b000100;
    // All ones parks the core
    localparam logic [5:0] OPC_HALT  = 6'b111111;

    // Funct field of R-type, bits 5 to 0
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLL  = 6'b000000;

    ////////////////////////////////////////////////////////////////////////////
    // Control types
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLL
    } alu_op_e;

    // One state per multicycle step, plus idle and halt
    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_WB, ST_HALT
    } state_e;

    // Decoded control, latched once per instruction
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;    // B input from the immediate
        logic    zero_ext;   // ORI style immediate
        logic    reg_write;
        logic    dst_is_rd;  // R-type destination, else rt
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    halt;
    } ctrl_t;

endpackage

//--- source/instr_rom.sv
`timescale 1ns/10ps

module instr_rom
(
    input  logic            i_clk,
    input  mips_pkg::addr_t addr,
    output mips_pkg::word_t instr
);

    // Program storage, one entry per instruction word
    mips_pkg::word_t mem [mips_pkg::ROM_WORDS];

    // Image comes from the hex file
    // one word per line, word 0 first
    initial
    begin
        $readmemh("source/program.hex", mem);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registered read
    ////////////////////////////////////////////////////////////////////////////

    // Byte address in, word index is bits 7 to 2
    // Word shows up one clock after the address
    always_ff @(posedge i_clk)
    begin
        instr <= mem[addr[7:2]];
    end

endmodule

//--- source/reg_file.sv
`timescale 1ns/10ps

module reg_file
(
    input  logic               i_clk,
    input  logic               arst_n,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::reg_idx_t dbg_idx,
    input  logic               wr_en,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_data,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    dbg_data
);

    mips_pkg::word_t regs [32];

    // Single write port, r0 never takes a write
    always_ff @(posedge i_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en && (wr_idx != '0))
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Combinational reads, entry 0 keeps its reset zero
    assign rs_data  = regs[rs_idx];
    assign rt_data  = regs[rt_idx];
    // Host side view, only meaningful while idle or halted
    assign dbg_data = regs[dbg_idx];

    // r0 stays zero across every write the core issues
    assert property (@(posedge i_clk) disable iff (!arst_n) regs[0] == '0);

endmodule

//--- source/alu.sv
`timescale 1ns/10ps

module alu
(
    input  mips_pkg::alu_op_e op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    output mips_pkg::word_t   result,
    output logic              zero
);

    ////////////////////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (op)
            // ADD, ADDU, ADDI and load/store address
            mips_pkg::ALU_ADD:
                result = a + b;
            // SUB, SUBU and BEQ compare
            mips_pkg::ALU_SUB:
                result = a - b;
            mips_pkg::ALU_AND:
                result = a & b;
            // OR and ORI
            mips_pkg::ALU_OR:
                result = a | b;
            mips_pkg::ALU_XOR:
                result = a ^ b;
            mips_pkg::ALU_NOR:
                result = ~(a | b);
            // Signed compare, SLT and SLTI
            mips_pkg::ALU_SLT:
                result = {31'b0, $signed(a) < $signed(b)};
            // Shift of rt, rs is ignored
            mips_pkg::ALU_SLL:
                result = b << shamt;
            default:
                result = '0;
        endcase
    end

    // Equal operands under subtract give zero, used by BEQ
    assign zero = (result == '0);

endmodule

//--- source/data_ram.sv
`timescale 1ns/10ps

module data_ram
(
    input  logic            i_clk,
    input  logic            arst_n,
    input  mips_pkg::addr_t addr,
    input  logic            wr_en,
    input  mips_pkg::word_t wr_data,
    output mips_pkg::word_t rd_data
);

    mips_pkg::word_t mem [mips_pkg::RAM_WORDS];

    // Word index is bits 5 to 2 of the byte address
    always_ff @(posedge i_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < mips_pkg::RAM_WORDS; i++)
                mem[i] <= '0;
        end
        else if (wr_en)
        begin
            mem[addr[5:2]] <= wr_data;
        end
    end

    // Read path is plain combinational
    assign rd_data = mem[addr[5:2]];

    // Stores land on word boundaries only
    assert property (@(posedge i_clk) disable iff (!arst_n) wr_en |-> addr[1:0] == 2'b00);

endmodule

//--- source/control_fsm.sv
`timescale 1ns/10ps

module control_fsm
(
    input  logic              i_clk,
    input  logic              arst_n,
    input  logic              req,
    output logic              ack,
    input  mips_pkg::addr_t   start_pc,
    input  mips_pkg::word_t   instr,
    input  logic              alu_zero,
    output mips_pkg::addr_t   pc,
    output mips_pkg::ctrl_t   ctrl,
    output mips_pkg::state_e  state,
    input  mips_pkg::addr_t   branch_off
);

    mips_pkg::state_e state_nxt;
    mips_pkg::ctrl_t  dec;
    logic [5:0]       opcode;
    logic [5:0]       funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    ////////////////////////////////////////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////////////////////////////////////////

    // Unknown encodings fall out as all zero, a no-op
    always_comb
    begin
        dec = '0;
        dec.alu_op = mips_pkg::ALU_ADD;
        case (opcode)
            mips_pkg::OPC_RTYPE:
            begin
                dec.reg_write = 1'b1;
                dec.dst_is_rd = 1'b1;
                case (funct)
                    mips_pkg::FN_ADD, mips_pkg::FN_ADDU:
                        dec.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB, mips_pkg::FN_SUBU:
                        dec.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR: dec.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR: dec.alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT: dec.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL: dec.alu_op = mips_pkg::ALU_SLL;
                    // Unsupported funct writes nothing
                    default:          dec.reg_write = 1'b0;
                endcase
            end
            // Address is base plus signed offset
            mips_pkg::OPC_LW:
            begin
                dec.use_imm   = 1'b1;
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_pkg::OPC_SW:
            begin
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            mips_pkg::OPC_ADDI:
            begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_pkg::OPC_ORI:
            begin
                dec.alu_op    = mips_pkg::ALU_OR;
                dec.use_imm   = 1'b1;
                dec.zero_ext  = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_pkg::OPC_SLTI:
            begin
                dec.alu_op    = mips_pkg::ALU_SLT;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            // Compare by subtract, zero flag decides
            mips_pkg::OPC_BEQ:
            begin
                dec.alu_op = mips_pkg::ALU_SUB;
                dec.branch = 1'b1;
            end
            mips_pkg::OPC_HALT:
                dec.halt = 1'b1;
            default:
                dec.halt = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Step sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            // New run only with ack already low
            mips_pkg::ST_IDLE:
                if (req && !ack)
                    state_nxt = mips_pkg::ST_FETCH;
            mips_pkg::ST_FETCH:
                state_nxt = mips_pkg::ST_DECODE;
            mips_pkg::ST_DECODE:
                state_nxt = dec.halt ? mips_pkg::ST_HALT : mips_pkg::ST_EXEC;
            // Loads and stores go through memory, others may skip it
            mips_pkg::ST_EXEC:
                if (ctrl.mem_read || ctrl.mem_write)
                    state_nxt = mips_pkg::ST_MEM;
                else if (ctrl.reg_write)
                    state_nxt = mips_pkg::ST_WB;
                else
                    state_nxt = mips_pkg::ST_FETCH;
            mips_pkg::ST_MEM:
                state_nxt = ctrl.mem_read ? mips_pkg::ST_WB : mips_pkg::ST_FETCH;
            mips_pkg::ST_WB:
                state_nxt = mips_pkg::ST_FETCH;
            // Park until the host lets go of req
            mips_pkg::ST_HALT:
                if (!req)
                    state_nxt = mips_pkg::ST_IDLE;
            default:
                state_nxt = mips_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= mips_pkg::ST_IDLE;
            ack   <= 1'b0;
            pc    <= '0;
            ctrl  <= '0;
        end
        else
        begin
            state <= state_nxt;
            // ack follows halt, drops on the way back to idle
            ack   <= (state_nxt == mips_pkg::ST_HALT);
            case (state)
                mips_pkg::ST_IDLE:
                    if (req && !ack)
                        pc <= start_pc;
                // PC points past the fetched word from decode on
                mips_pkg::ST_FETCH:
                    pc <= pc + 8'd4;
                mips_pkg::ST_DECODE:
                    ctrl <= dec;
                mips_pkg::ST_EXEC:
                    if (ctrl.branch && alu_zero)
                        pc <= pc + branch_off;
                default:
                    pc <= pc;
            endcase
        end
    end

    // ack only while parked in halt
    assert property (@(posedge i_clk) disable iff (!arst_n)
        ack |-> state == mips_pkg::ST_HALT);
    // A store never also writes back
    assert property (@(posedge i_clk) disable iff (!arst_n)
        (state inside {mips_pkg::ST_MEM, mips_pkg::ST_WB})
        |-> !(ctrl.mem_write && ctrl.reg_write));

endmodule

//--- source/mips_core.sv
`timescale 1ns/10ps

module mips_core
(
    input  logic               i_clk,
    input  logic               arst_n,
    input  logic               req,
    output logic               ack,
    input  mips_pkg::addr_t    start_pc,
    input  mips_pkg::reg_idx_t dbg_idx,
    output mips_pkg::word_t    dbg_data
);

    mips_pkg::addr_t  pc;
    mips_pkg::addr_t  branch_off;
    mips_pkg::ctrl_t  ctrl;
    mips_pkg::state_e state;
    mips_pkg::word_t  rom_instr;
    mips_pkg::word_t  ir;
    mips_pkg::word_t  instr_cur;
    mips_pkg::word_t  rf_rs;
    mips_pkg::word_t  rf_rt;
    mips_pkg::word_t  op_a;
    mips_pkg::word_t  op_b;
    mips_pkg::word_t  imm_ext;
    mips_pkg::word_t  alu_b;
    mips_pkg::word_t  alu_out;
    mips_pkg::word_t  alu_res;
    mips_pkg::word_t  ram_rd_data;
    mips_pkg::word_t  mdr;
    mips_pkg::word_t  rf_wr_data;
    mips_pkg::reg_idx_t rf_wr_idx;
    logic             alu_zero;
    logic             rf_wr_en;
    logic             ram_wr_en;

    // ROM word is fresh in decode, IR holds it after that
    assign instr_cur = (state == mips_pkg::ST_DECODE) ? rom_instr : ir;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (state == mips_pkg::ST_DECODE)
        begin
            ir   <= rom_instr;
            op_a <= rf_rs;
            op_b <= rf_rt;
        end
        if (state == mips_pkg::ST_EXEC)
            alu_res <= alu_out;
        // Load data captured at the end of memory step
        if (state == mips_pkg::ST_MEM)
            mdr <= ram_rd_data;
    end

    // Immediate, ORI zero fills, others sign extend
    assign imm_ext = ctrl.zero_ext ? {16'h0000, instr_cur[15:0]}
                                   : {{16{instr_cur[15]}}, instr_cur[15:0]};
    // Branch offset in bytes, truncated to the PC width
    assign branch_off = {instr_cur[5:0], 2'b00};
    assign alu_b      = ctrl.use_imm ? imm_ext : op_b;

    // Write enables only in their own step
    assign rf_wr_en   = (state == mips_pkg::ST_WB) && ctrl.reg_write;
    assign ram_wr_en  = (state == mips_pkg::ST_MEM) && ctrl.mem_write;
    assign rf_wr_idx  = ctrl.dst_is_rd ? instr_cur[15:11] : instr_cur[20:16];
    assign rf_wr_data = ctrl.mem_read ? mdr : alu_res;

    ////////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////////

    instr_rom u_rom (.i_clk(i_clk), .addr(pc), .instr(rom_instr));

    reg_file u_rf
    (
        .i_clk(i_clk), .arst_n(arst_n),
        .rs_idx(instr_cur[25:21]), .rt_idx(instr_cur[20:16]), .dbg_idx(dbg_idx),
        .wr_en(rf_wr_en), .wr_idx(rf_wr_idx), .wr_data(rf_wr_data),
        .rs_data(rf_rs), .rt_data(rf_rt), .dbg_data(dbg_data)
    );

    alu u_alu
    (
        .op(ctrl.alu_op), .a(op_a), .b(alu_b), .shamt(instr_cur[10:6]),
        .result(alu_out), .zero(alu_zero)
    );

    // Address from the latched result, store data is rt
    data_ram u_ram
    (
        .i_clk(i_clk), .arst_n(arst_n), .addr(alu_res[7:0]),
        .wr_en(ram_wr_en), .wr_data(op_b), .rd_data(ram_rd_data)
    );

    control_fsm u_fsm
    (
        .i_clk(i_clk), .arst_n(arst_n), .req(req), .ack(ack), .start_pc(start_pc),
        .instr(instr_cur), .alu_zero(alu_zero), .pc(pc), .ctrl(ctrl),
        .state(state), .branch_off(branch_off)
    );

endmodule

//--- dv/mips_core_tb.sv
`timescale 1ns/10ps

module mips_core_tb;

    ////////////////////////////////////////////////////////////////////////////
    // Constants and table types
    ////////////////////////////////////////////////////////////////////////////

    localparam int TIMEOUT_CYCLES = 500;
    // ORI r1 with 0x00f0, zero extended
    localparam mips_pkg::word_t OP_A = 32'h0000_00F0;
    // ADDI r2 with -3, sign extended
    localparam mips_pkg::word_t OP_B = 32'hFFFF_FFFD;

    // One expected register value
    typedef struct packed {
        mips_pkg::reg_idx_t idx;
        mips_pkg::word_t    value;
    } reg_exp_t;

    // One run, its expectations are a slice of the expectation list
    typedef struct packed {
        mips_pkg::addr_t start;
        int              first;
        int              count;
    } run_row_t;

    logic               i_clk;
    logic               arst_n;
    logic               req;
    logic               ack;
    mips_pkg::addr_t    start_pc;
    mips_pkg::reg_idx_t dbg_idx;
    mips_pkg::word_t    dbg_data;

    reg_exp_t exp_q [$];
    run_row_t run_q [$];
    int       n_checks;
    int       n_errors;
    logic     timed_out;

    mips_core UUT
    (
        .i_clk(i_clk), .arst_n(arst_n), .req(req), .ack(ack), .start_pc(start_pc),
        .dbg_idx(dbg_idx), .dbg_data(dbg_data)
    );

    // 4 ns period
    always #2 i_clk = ~i_clk;

    ////////////////////////////////////////////////////////////////////////////
    // Table
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_exp(input int idx, input mips_pkg::word_t value);
        reg_exp_t e;
        e.idx   = mips_pkg::reg_idx_t'(idx);
        e.value = value;
        exp_q.push_back(e);
    endtask

    task automatic add_run(input mips_pkg::addr_t start, input int first, input int count);
        run_row_t row;
        row.start = start;
        row.first = first;
        row.count = count;
        run_q.push_back(row);
    endtask

    task automatic build_table();
        // Arithmetic, r0 stays zero after ADD r0
        add_exp(0, '0);
        add_exp(1, OP_A);
        add_exp(2, OP_B);
        // 240 plus -3
        add_exp(3, 32'h0000_00ED);
        add_exp(4, 32'h0000_00ED);
        // 240 minus -3
        add_exp(5, 32'h0000_00F3);
        add_exp(6, 32'h0000_00F3);
        add_exp(7, 32'h0000_00F0);
        add_exp(8, 32'hFFFF_FFFD);
        add_exp(9, 32'hFFFF_FF0D);
        add_exp(10, 32'h0000_0002);
        // SLT r2 < r1 as signed, -3 below 240
        add_exp(11, 32'd1);
        // SLTI r2 < -2
        add_exp(12, 32'd1);
        // r1 moved up one hex digit
        add_exp(13, 32'h0000_0F00);
        // Memory, loads return what was stored
        add_exp(1, OP_A);
        add_exp(2, OP_B);
        add_exp(14, OP_A);
        add_exp(15, OP_B);
        // Branch, taken BEQ skips r16, untaken one lets r17 through
        add_exp(16, '0);
        add_exp(17, 32'd7);
        add_exp(18, 32'd5);
        add_exp(19, 32'd5);

        add_run(8'h00, 0, 14);
        add_run(8'h60, 14, 4);
        add_run(8'hA0, 18, 4);
        // Arithmetic again after the other segments
        add_run(8'h00, 0, 14);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host side helpers
    ////////////////////////////////////////////////////////////////////////////

    // Debug port is combinational, one precision step is enough
    task automatic read_reg(input mips_pkg::reg_idx_t idx, output mips_pkg::word_t value);
        dbg_idx = idx;
        #0.01;
        value = dbg_data;
    endtask

    task automatic wait_ack(input logic level, input int run, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < TIMEOUT_CYCLES)
        begin
            @(posedge i_clk);
            #1;
            n++;
            if (ack == level)
                ok = 1'b1;
        end
        if (!ok)
        begin
            $display("TIMEOUT at %0t: ack did not go %0s within %0d cycles in run %0d",
                     $time, level ? "high" : "low", TIMEOUT_CYCLES, run);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_reset();
        mips_pkg::word_t got;
        int              errs_before;
        errs_before = n_errors;
        n_checks++;
        assert (ack == 1'b0)
        else
        begin
            $display("ERR %0t: ack high after reset", $time);
            n_errors++;
        end
        for (int i = 1; i < 32; i++)
        begin
            read_reg(mips_pkg::reg_idx_t'(i), got);
            n_checks++;
            assert (got == '0)
            else
            begin
                $display("ERR %0t: r%0d reads 0x%08h after reset", $time, i, got);
                n_errors++;
            end
        end
        $display("reset: %0d errors", n_errors - errs_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One run through the handshake
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_run(input int r);
        run_row_t        row;
        reg_exp_t        e;
        mips_pkg::word_t snap [32];
        mips_pkg::word_t got;
        int unsigned     gap;
        int unsigned     hold;
        int              errs_before;
        int              checks_before;
        logic            ok;

        row           = run_q[r];
        errs_before   = n_errors;
        checks_before = n_checks;
        gap           = $urandom % 8;
        hold          = 1 + ($urandom % 10);

        // start_pc settles before req goes up
        @(posedge i_clk);
        #1;
        start_pc = row.start;
        repeat (gap)
        begin
            @(posedge i_clk);
            #1;
        end
        @(posedge i_clk);
        #1;
        req = 1'b1;
        wait_ack(1'b1, r, ok);
        if (!ok)
            return;

        // Core is halted, take a copy of every register
        for (int i = 0; i < 32; i++)
        begin
            read_reg(mips_pkg::reg_idx_t'(i), got);
            snap[i] = got;
        end

        // req held on, ack must stay up
        repeat (hold)
        begin
            @(posedge i_clk);
            #1;
            n_checks++;
            assert (ack == 1'b1)
            else
            begin
                $display("ERR %0t: ack dropped while req held in run %0d", $time, r);
                n_errors++;
            end
        end
        req = 1'b0;

        // Nothing may have moved during the hold
        for (int i = 0; i < 32; i++)
        begin
            read_reg(mips_pkg::reg_idx_t'(i), got);
            n_checks++;
            assert (got == snap[i])
            else
            begin
                $display("ERR %0t: r%0d changed to 0x%08h while halted in run %0d",
                         $time, i, got, r);
                n_errors++;
            end
        end

        wait_ack(1'b0, r, ok);
        if (!ok)
            return;

        for (int i = row.first; i < row.first + row.count; i++)
        begin
            e = exp_q[i];
            read_reg(e.idx, got);
            n_checks++;
            assert (got == e.value)
            else
            begin
                $display("ERR %0t: run %0d r%0d reads 0x%08h, expected 0x%08h",
                         $time, r, e.idx, got, e.value);
                n_errors++;
            end
        end

        $display("run %0d start 0x%02h gap %0d hold %0d: %0d checks, %0d errors",
                 r, row.start, gap, hold, n_checks - checks_before, n_errors - errs_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        i_clk     = 1'b0;
        arst_n    = 1'b0;
        req       = 1'b0;
        start_pc  = '0;
        dbg_idx   = '0;
        n_checks  = 0;
        n_errors  = 0;
        timed_out = 1'b0;
        void'($urandom(72));
        build_table();

        // Reset over 4 clocks, released just after an edge
        repeat (4) @(posedge i_clk);
        #1;
        arst_n = 1'b1;
        check_reset();

        for (int r = 0; r < run_q.size(); r++)
        begin
            if (!timed_out)
                apply_run(r);
        end

        $display("runs %0d, checks %0d, errors %0d, timeout %0d",
                 run_q.size(), n_checks, n_errors, timed_out);
        if (n_errors == 0 && !timed_out)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- source/program.hex
// One 32-bit instruction word per line in hex, word 0 first
// An @ line moves the load point to the word index that follows it

// Arithmetic segment at byte address 0x00
340100f0
2002fffd
00221820
00222021
00222822
00223023
00223824
00224025
00224826
00225027
0041582a
284cfffe
00016900
00210020
fc000000

// Memory segment at byte address 0x60
@18
340100f0
2002fffd
ac01000c
ac020014
8c0e000c
8c0f0014
fc000000

// Branch segment at byte address 0xa0
@28
34120005
20130005
12530001
20100009
12400001
20110007
fc000000

//--- mips_core.f
source/mips_pkg.sv
source/instr_rom.sv
source/reg_file.sv
source/alu.sv
source/data_ram.sv
source/control_fsm.sv
source/mips_core.sv
dv/mips_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f mips_core.f --top-module mips_core_tb -o mips_core_sim

out=$(./obj_dir/mips_core_sim)
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
else
    exit 1
fi
